//--- filelist.f
qa_pkg.sv
qa_fiu_tap.sv
qa_csr.sv
qa_driver_top.sv
tb_qa_driver.sv

//--- qa_csr.sv
/*
 * Driver CSR block.
 * Decodes host MMIO requests arriving on c0 receive, holds the DSM base
 * address with its valid flag and a scratch register, and answers each
 * MMIO read with one response on c2 transmit a cycle later.
 */

module qa_csr
(
    input  logic               clk,
    input  logic               reset,

    // Host MMIO requests share the c0 receive channel with read data
    input  qa_pkg::t_c0_rx     c0_rx,

    // MMIO read responses
    output qa_pkg::t_c2_tx     c2_tx,

    // Register values for the host tap
    output qa_pkg::t_csr_state csr
);

    import qa_pkg::*;

    // MMIO request view of the incoming header
    t_mmio_req_hdr mmio_hdr;

    logic mmio_wr;
    logic mmio_rd;

    // Value returned for the address in the current read request
    t_mmio_data rd_data;

    always_comb
    begin
        mmio_hdr = c0_rx.hdr.mmio;

        mmio_wr = c0_rx.valid && (mmio_hdr.rsp_type == rsp_mmio_wr_req);
        mmio_rd = c0_rx.valid && (mmio_hdr.rsp_type == rsp_mmio_rd_req);
    end

    // Read decode
    // Unmapped addresses return zero
    always_comb
    begin
        rd_data = '0;

        case (mmio_hdr.address)
            csr_addr_dsm_base:
            begin
                rd_data = t_mmio_data'(csr.dsm_base);
            end
            csr_addr_scratch:
            begin
                rd_data = csr.scratch;
            end
            default:
            begin
                rd_data = '0;
            end
        endcase
    end

    // Register writes take effect on the next edge
    // Writing the DSM base also marks it valid, which starts the ID write
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            csr <= '0;
        end
        else if (mmio_wr)
        begin
            if (mmio_hdr.address == csr_addr_dsm_base)
            begin
                csr.dsm_base       <= c0_rx.data[31:0];
                csr.dsm_base_valid <= 1'b1;
            end

            if (mmio_hdr.address == csr_addr_scratch)
            begin
                csr.scratch <= c0_rx.data[63:0];
            end
        end
    end

    // One response per read request, exactly one cycle later
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            c2_tx.valid <= 1'b0;
        end
        else
        begin
            c2_tx.valid <= mmio_rd;
        end
    end

    // Response payload keeps the request's tid
    always_ff @(posedge clk)
    begin
        if (mmio_rd)
        begin
            c2_tx.tid  <= mmio_hdr.tid;
            c2_tx.data <= rd_data;
        end
    end

endmodule

//--- qa_driver_top.sv
/*
 * Driver shell top level.
 * Joins the host tap and the CSR block. The CSR block watches the c0
 * receive stream that the tap hands to the accelerator and sends its MMIO
 * read responses back through the tap.
 */

module qa_driver_top
(
    input  logic           clk,
    input  logic           reset,

    // Platform side
    output qa_pkg::t_c0_tx fiu_c0_tx,
    output qa_pkg::t_c1_tx fiu_c1_tx,
    output qa_pkg::t_c2_tx fiu_c2_tx,
    input  logic           fiu_c0_alm_full,
    input  logic           fiu_c1_alm_full,
    input  qa_pkg::t_c0_rx fiu_c0_rx,
    input  qa_pkg::t_c1_rx fiu_c1_rx,

    // Accelerator side, which has no MMIO response channel
    input  qa_pkg::t_c0_tx afu_c0_tx,
    input  qa_pkg::t_c1_tx afu_c1_tx,
    output logic           afu_c0_alm_full,
    output logic           afu_c1_alm_full,
    output qa_pkg::t_c0_rx afu_c0_rx,
    output qa_pkg::t_c1_rx afu_c1_rx
);

    import qa_pkg::*;

    // MMIO read responses from the CSR block into the tap
    t_c2_tx     csr_c2_tx;

    // CSR values watched by the tap
    t_csr_state csr_state;

    qa_fiu_tap tap
    (
        .clk             (clk),
        .reset           (reset),
        .fiu_c0_tx       (fiu_c0_tx),
        .fiu_c1_tx       (fiu_c1_tx),
        .fiu_c2_tx       (fiu_c2_tx),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c1_alm_full (fiu_c1_alm_full),
        .fiu_c0_rx       (fiu_c0_rx),
        .fiu_c1_rx       (fiu_c1_rx),
        .afu_c0_tx       (afu_c0_tx),
        .afu_c1_tx       (afu_c1_tx),
        .afu_c2_tx       (csr_c2_tx),
        .afu_c0_alm_full (afu_c0_alm_full),
        .afu_c1_alm_full (afu_c1_alm_full),
        .afu_c0_rx       (afu_c0_rx),
        .afu_c1_rx       (afu_c1_rx),
        .csr             (csr_state)
    );

    // The CSR block sees the same c0 receive stream as the accelerator
    qa_csr csr_regs
    (
        .clk   (clk),
        .reset (reset),
        .c0_rx (afu_c0_rx),
        .c2_tx (csr_c2_tx),
        .csr   (csr_state)
    );

endmodule

//--- qa_fiu_tap.sv
/*
 * Host interface tap of the driver shell.
 * Passes all channels between the platform and the accelerator. In idle
 * write slots it injects the accelerator ID write to DSM line 0 and maps
 * the pending MMIO read response onto a write to DSM line 1. Write
 * responses carrying the driver tag are removed from the accelerator side.
 */

module qa_fiu_tap
(
    input  logic               clk,
    input  logic               reset,

    // Platform side
    output qa_pkg::t_c0_tx     fiu_c0_tx,
    output qa_pkg::t_c1_tx     fiu_c1_tx,
    output qa_pkg::t_c2_tx     fiu_c2_tx,
    input  logic               fiu_c0_alm_full,
    input  logic               fiu_c1_alm_full,
    input  qa_pkg::t_c0_rx     fiu_c0_rx,
    input  qa_pkg::t_c1_rx     fiu_c1_rx,

    // Accelerator side
    input  qa_pkg::t_c0_tx     afu_c0_tx,
    input  qa_pkg::t_c1_tx     afu_c1_tx,
    input  qa_pkg::t_c2_tx     afu_c2_tx,
    output logic               afu_c0_alm_full,
    output logic               afu_c1_alm_full,
    output qa_pkg::t_c0_rx     afu_c0_rx,
    output qa_pkg::t_c1_rx     afu_c1_rx,

    // Driver CSR values
    input  qa_pkg::t_csr_state csr
);

    import qa_pkg::*;

    // Set once the accelerator ID write has actually gone out
    logic did_afu_id_write;

    // Single holding register for an MMIO read response waiting for a
    // free write slot
    // Only one MMIO read may be in flight, so one entry is enough
    logic       mmio_rsp_valid;
    t_mmio_data mmio_rsp_data;

    // A write slot is free when the platform accepts writes and the
    // accelerator is not using the slot itself
    logic slot_free;
    logic inject_afu_id;
    logic inject_mmio_rsp;

    always_comb
    begin
        slot_free = !fiu_c1_alm_full && !afu_c1_tx.valid;

        // The ID write comes first, the MMIO response waits behind it
        inject_afu_id   = slot_free && csr.dsm_base_valid && !did_afu_id_write;
        inject_mmio_rsp = slot_free && !inject_afu_id && mmio_rsp_valid;
    end

    // Request channels toward the platform
    always_comb
    begin
        fiu_c0_tx       = afu_c0_tx;
        afu_c0_alm_full = fiu_c0_alm_full;
        afu_c1_alm_full = fiu_c1_alm_full;
        fiu_c2_tx       = afu_c2_tx;

        fiu_c1_tx = afu_c1_tx;

        if (inject_afu_id)
        begin
            // DSM line 0 gets the accelerator ID
            fiu_c1_tx.valid    = 1'b1;
            fiu_c1_tx.req_type = req_wrline;
            fiu_c1_tx.address  = csr.dsm_base;
            fiu_c1_tx.mdata    = qa_driver_write_tag;
            fiu_c1_tx.data     = qa_afu_id;
        end
        else if (inject_mmio_rsp)
        begin
            // DSM line 1 gets the MMIO read data in the low 64 bits
            // Bit 64 tells software that the line has been written
            fiu_c1_tx.valid    = 1'b1;
            fiu_c1_tx.req_type = req_wrline;
            fiu_c1_tx.address  = csr.dsm_base + t_line_addr'(1);
            fiu_c1_tx.mdata    = qa_driver_write_tag;
            fiu_c1_tx.data     = {63'b0, 1'b1, mmio_rsp_data};
        end
    end

    // Response channels toward the accelerator
    always_comb
    begin
        afu_c0_rx = fiu_c0_rx;
        afu_c1_rx = fiu_c1_rx;

        // Responses to the driver's own writes stop here
        if (fiu_c1_rx.valid && (fiu_c1_rx.mdata == qa_driver_write_tag))
        begin
            afu_c1_rx.valid = 1'b0;
        end
    end

    // The ID write is tracked only when it is really issued, so
    // back-pressure just postpones it
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            did_afu_id_write <= 1'b0;
        end
        else if (inject_afu_id)
        begin
            did_afu_id_write <= 1'b1;
        end
    end

    // Capture an MMIO read response while the holding register is empty
    // and release it once its write has been issued
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mmio_rsp_valid <= 1'b0;
        end
        else if (inject_mmio_rsp)
        begin
            mmio_rsp_valid <= 1'b0;
        end
        else if (!mmio_rsp_valid)
        begin
            mmio_rsp_valid <= afu_c2_tx.valid;
        end
    end

    // Response data follows the same capture condition
    always_ff @(posedge clk)
    begin
        if (!mmio_rsp_valid)
        begin
            mmio_rsp_data <= afu_c2_tx.data;
        end
    end

endmodule

//--- qa_pkg.sv
/*
 * Shared definitions for the accelerator driver shell host tap.
 * Holds the reduced host-interface channel structs, the c0 receive header
 * union, request and response codes, the MMIO register map and the
 * constants that the tap injects into device status memory.
 */

package qa_pkg;

    // Accelerator ID that software finds in DSM line 0
    localparam logic [127:0] qa_afu_id = 128'h5f3c_91a0_4d7e_4b2a_8c16_0e93_b41f_7c0e;

    // Request tag that marks writes injected by the driver
    // The user accelerator must never issue a write with this tag
    localparam logic [7:0] qa_driver_write_tag = 8'hfe;

    // MMIO byte addresses of the driver CSRs
    localparam logic [15:0] csr_addr_dsm_base = 16'h0100;
    localparam logic [15:0] csr_addr_scratch  = 16'h0108;

    // Scalar types shared by all channels
    typedef logic [31:0]  t_line_addr;
    typedef logic [7:0]   t_mdata;
    typedef logic [127:0] t_line_data;
    typedef logic [63:0]  t_mmio_data;

    // Memory request codes on the transmit channels
    typedef enum logic [1:0]
    {
        req_wrline = 2'b00,
        req_rdline = 2'b01
    } t_req_type;

    // Response codes on c0 receive
    // MMIO requests from the host share the c0 receive channel with read data
    typedef enum logic [1:0]
    {
        rsp_read        = 2'b00,
        rsp_write       = 2'b01,
        rsp_mmio_wr_req = 2'b10,
        rsp_mmio_rd_req = 2'b11
    } t_rsp_type;

    // Write request on c1 transmit
    typedef struct packed
    {
        logic       valid;
        t_req_type  req_type;
        t_line_addr address;
        t_mdata     mdata;
        t_line_data data;
    } t_c1_tx;

    // Read request on c0 transmit
    typedef struct packed
    {
        logic       valid;
        t_line_addr address;
        t_mdata     mdata;
    } t_c0_tx;

    // MMIO read response on c2 transmit
    // The tid echoes the tid of the MMIO read request
    typedef struct packed
    {
        logic       valid;
        logic [8:0] tid;
        t_mmio_data data;
    } t_c2_tx;

    // Write response on c1 receive
    typedef struct packed
    {
        logic   valid;
        t_mdata mdata;
    } t_c1_rx;

    // Memory response view of the c0 receive header
    // The reserved bits pad this view to the MMIO request width
    typedef struct packed
    {
        t_rsp_type   rsp_type;
        logic [16:0] rsvd;
        t_mdata      mdata;
    } t_mem_rsp_hdr;

    // MMIO request view of the c0 receive header
    typedef struct packed
    {
        t_rsp_type   rsp_type;
        logic [15:0] address;
        logic [8:0]  tid;
    } t_mmio_req_hdr;

    // One c0 receive header decoded two ways
    // The rsp_type field occupies the top two bits in both views, so either
    // view can be used to tell a read response from an MMIO request
    typedef union packed
    {
        t_mem_rsp_hdr  mem;
        t_mmio_req_hdr mmio;
    } t_c0_rx_hdr;

    // Response on c0 receive
    // For MMIO writes the register value travels in data[63:0]
    typedef struct packed
    {
        logic       valid;
        t_c0_rx_hdr hdr;
        t_line_data data;
    } t_c0_rx;

    // Driver CSR values that the host tap monitors
    typedef struct packed
    {
        t_line_addr dsm_base;
        logic       dsm_base_valid;
        t_mmio_data scratch;
    } t_csr_state;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build the driver shell testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_qa_driver -f filelist.f -o sim_tb_qa_driver

./obj_dir/sim_tb_qa_driver | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run_sim: the testbench reported a failure"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: the simulation ended without a verdict"
    exit 1
fi

echo "run_sim: done"

//--- tb_qa_driver.sv
/*
 * Self-checking testbench for the driver shell top level.
 * A host model drives MMIO requests, back-pressure, accelerator writes
 * and write responses. A reference model predicts the platform write
 * channel and the response streams, which are compared every cycle.
 */

module tb_qa_driver;

    import qa_pkg::*;

    logic   clk;
    logic   reset;
    t_c0_tx fiu_c0_tx;
    t_c1_tx fiu_c1_tx;
    t_c2_tx fiu_c2_tx;
    logic   fiu_c0_alm_full;
    logic   fiu_c1_alm_full;
    t_c0_rx fiu_c0_rx;
    t_c1_rx fiu_c1_rx;
    t_c0_tx afu_c0_tx;
    t_c1_tx afu_c1_tx;
    logic   afu_c0_alm_full;
    logic   afu_c1_alm_full;
    t_c0_rx afu_c0_rx;
    t_c1_rx afu_c1_rx;

    // Register values as the host model wrote them
    t_line_addr exp_base;
    logic       exp_base_valid;
    t_mmio_data exp_scratch;

    // Pending injections are the ID write, the MMIO response leaving the CSR
    // block and the response held for a free write slot
    logic       exp_id_done;
    logic       exp_c2_valid;
    logic [8:0] exp_c2_tid;
    t_mmio_data exp_c2_data;
    logic       exp_hold_valid;
    t_mmio_data exp_hold_data;

    t_c1_tx     exp_c1;
    t_c1_rx     exp_c1_rx;
    t_line_data last_mmio_line;
    int         id_writes;
    int         mmio_writes;
    int         check_count;
    int         error_count;
    int         tests_run;
    logic       timed_out;

    qa_driver_top dut (.*);

    always #10 clk = ~clk;

    // Expected platform write for one cycle
    // The accelerator owns the slot whenever it sends, otherwise the ID write
    // goes first and the held MMIO response follows
    function automatic t_c1_tx expected_fiu_c1(input t_c1_tx afu_req, input logic alm_full,
        input t_line_addr base, input logic id_pending, input logic hold_valid,
        input t_mmio_data hold_data);
        t_c1_tx wr;
        wr = afu_req;
        if (!alm_full && !afu_req.valid && (id_pending || hold_valid))
        begin
            wr.valid    = 1'b1;
            wr.req_type = req_wrline;
            wr.mdata    = qa_driver_write_tag;
            wr.address  = id_pending ? base : base + 32'd1;
            wr.data     = id_pending ? qa_afu_id : {63'b0, 1'b1, hold_data};
        end
        return wr;
    endfunction

    // MMIO read value of the register map
    // Unmapped addresses give zero
    function automatic t_mmio_data register_value(input logic [15:0] addr);
        if (addr == csr_addr_dsm_base)
            return {32'b0, exp_base};
        if (addr == csr_addr_scratch)
            return exp_scratch;
        return '0;
    endfunction

    function automatic t_c0_rx mmio_request(input t_rsp_type kind, input logic [15:0] addr,
        input logic [8:0] tid, input t_mmio_data value);
        t_c0_rx req;
        req                   = '0;
        req.valid             = 1'b1;
        req.hdr.mmio.rsp_type = kind;
        req.hdr.mmio.address  = addr;
        req.hdr.mmio.tid      = tid;
        req.data              = {64'b0, value};
        return req;
    endfunction

    function automatic t_c1_tx random_write();
        t_c1_tx wr;
        wr.valid    = 1'b1;
        wr.req_type = req_wrline;
        wr.address  = $urandom;
        // Any tag except the driver's own
        wr.mdata    = 8'($urandom % 254);
        wr.data     = {$urandom, $urandom, $urandom, $urandom};
        return wr;
    endfunction

    function automatic t_c0_tx random_read();
        t_c0_tx rd;
        rd.valid   = 1'b1;
        rd.address = $urandom;
        rd.mdata   = 8'($urandom);
        return rd;
    endfunction

    task automatic check_value(input string what, input logic [255:0] actual,
        input logic [255:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("** Error at time %0t: %s mismatch, got %h, expected %h",
                $time, what, actual, expected);
        end
    endtask

    // Compare on the falling edge, where every DUT output has settled,
    // then step the model to the next cycle
    always @(negedge clk)
    begin
        exp_c1 = expected_fiu_c1(afu_c1_tx, fiu_c1_alm_full, exp_base,
            exp_base_valid && !exp_id_done, exp_hold_valid, exp_hold_data);
        exp_c1_rx = fiu_c1_rx;
        if (fiu_c1_rx.mdata == qa_driver_write_tag)
            exp_c1_rx.valid = 1'b0;
        if (reset)
        begin
            exp_base       = '0;
            exp_base_valid = 1'b0;
            exp_scratch    = '0;
            exp_id_done    = 1'b0;
            exp_c2_valid   = 1'b0;
            exp_hold_valid = 1'b0;
        end
        else
        begin
            check_value("FIU c1 write", 256'(fiu_c1_tx), 256'(exp_c1));
            check_value("AFU c1 response", 256'(afu_c1_rx), 256'(exp_c1_rx));
            check_value("AFU c0 response", 256'(afu_c0_rx), 256'(fiu_c0_rx));
            check_value("FIU c0 read", 256'(fiu_c0_tx), 256'(afu_c0_tx));
            check_value("AFU c0 almost-full", 256'(afu_c0_alm_full), 256'(fiu_c0_alm_full));
            check_value("AFU c1 almost-full", 256'(afu_c1_alm_full), 256'(fiu_c1_alm_full));
            check_value("FIU c2 valid", 256'(fiu_c2_tx.valid), 256'(exp_c2_valid));
            if (exp_c2_valid)
                check_value("FIU c2 tid and data", 256'({fiu_c2_tx.tid, fiu_c2_tx.data}),
                    256'({exp_c2_tid, exp_c2_data}));

            // Tally the injected writes that really reached the platform
            if (fiu_c1_tx.valid && (fiu_c1_tx.mdata == qa_driver_write_tag))
            begin
                if (fiu_c1_tx.data == qa_afu_id)
                    id_writes++;
                else
                begin
                    mmio_writes++;
                    last_mmio_line = fiu_c1_tx.data;
                end
            end

            // An empty holding register takes whatever response is on c2
            if (!exp_hold_valid)
            begin
                exp_hold_valid = exp_c2_valid;
                exp_hold_data  = exp_c2_data;
            end
            else if (exp_c1.valid && (exp_c1.mdata == qa_driver_write_tag) &&
                (exp_c1.data != qa_afu_id))
                exp_hold_valid = 1'b0;
            if (exp_c1.valid && (exp_c1.mdata == qa_driver_write_tag) &&
                (exp_c1.data == qa_afu_id))
                exp_id_done = 1'b1;

            // Read responses come one cycle after the request
            exp_c2_valid = fiu_c0_rx.valid && (fiu_c0_rx.hdr.mmio.rsp_type == rsp_mmio_rd_req);
            exp_c2_tid   = fiu_c0_rx.hdr.mmio.tid;
            exp_c2_data  = register_value(fiu_c0_rx.hdr.mmio.address);
            if (fiu_c0_rx.valid && (fiu_c0_rx.hdr.mmio.rsp_type == rsp_mmio_wr_req))
            begin
                if (fiu_c0_rx.hdr.mmio.address == csr_addr_dsm_base)
                begin
                    exp_base       = fiu_c0_rx.data[31:0];
                    exp_base_valid = 1'b1;
                end
                if (fiu_c0_rx.hdr.mmio.address == csr_addr_scratch)
                    exp_scratch = fiu_c0_rx.data[63:0];
            end
        end
    end

    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(posedge clk);
            fiu_c0_alm_full <= 1'b0;
            fiu_c1_alm_full <= 1'b0;
            fiu_c0_rx       <= '0;
            fiu_c1_rx       <= '0;
            afu_c0_tx       <= '0;
            afu_c1_tx       <= '0;
        end
    endtask

    // One-cycle MMIO request
    // The next drive cycle takes it away again
    task automatic send_mmio(input t_rsp_type kind, input logic [15:0] addr,
        input logic [8:0] tid, input t_mmio_data value);
        idle_cycles(1);
        fiu_c0_rx <= mmio_request(kind, addr, tid, value);
    endtask

    task automatic drive_random_cycle(input logic with_responses);
        logic   full;
        logic   rd_full;
        t_c1_rx wr_rsp;
        t_c0_rx rd_rsp;
        full    = ($urandom % 4) == 0;
        rd_full = ($urandom % 4) == 0;
        idle_cycles(1);
        fiu_c0_alm_full <= rd_full;
        fiu_c1_alm_full <= full;
        // The accelerator only sends while the platform has room
        if (!full && (($urandom % 2) == 1))
            afu_c1_tx <= random_write();
        if (!rd_full && (($urandom % 2) == 1))
            afu_c0_tx <= random_read();
        if (with_responses)
        begin
            wr_rsp.valid            = 1'($urandom % 2);
            wr_rsp.mdata            = (($urandom % 3) == 0) ? qa_driver_write_tag : 8'($urandom);
            rd_rsp                  = '0;
            rd_rsp.valid            = 1'($urandom % 2);
            rd_rsp.hdr.mem.rsp_type = rsp_read;
            rd_rsp.hdr.mem.mdata    = 8'($urandom);
            rd_rsp.data             = {$urandom, $urandom, $urandom, $urandom};
            fiu_c1_rx <= wr_rsp;
            fiu_c0_rx <= rd_rsp;
        end
    endtask

    task automatic wait_for_writes(input int id_target, input int mmio_target, input string what);
        int cycles;
        cycles = 0;
        while (((id_writes < id_target) || (mmio_writes < mmio_target)) && (cycles < 100))
        begin
            idle_cycles(1);
            cycles++;
        end
        if ((id_writes < id_target) || (mmio_writes < mmio_target))
        begin
            timed_out = 1'b1;
            $display("Timeout: no %s appeared on the FIU write channel within %0d cycles",
                what, cycles);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("Test %0d %s: %s, %0d errors", tests_run, name,
            (error_count == errors_before) ? "ok" : "failed", error_count - errors_before);
    endtask

    initial
    begin
        int         errors_before;
        int         mmio_before;
        t_mmio_data scratch;

        void'($urandom(32'h7ad1505b));
        reset           = 1'b1;
        clk             = 1'b0;
        fiu_c0_alm_full = 1'b0;
        fiu_c1_alm_full = 1'b0;
        fiu_c0_rx       = '0;
        fiu_c1_rx       = '0;
        afu_c0_tx       = '0;
        afu_c1_tx       = '0;
        id_writes       = 0;
        mmio_writes     = 0;
        check_count     = 0;
        error_count     = 0;
        tests_run       = 0;
        timed_out       = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // No DSM base yet, so only accelerator writes may appear
        errors_before = error_count;
        repeat (40) drive_random_cycle(1'b0);
        idle_cycles(2);
        check_value("injected writes before DSM base", 256'(id_writes + mmio_writes), 256'(0));
        report_test("pass-through before DSM base", errors_before);

        // Back-pressure and then an accelerator write hold the ID write back
        errors_before = error_count;
        send_mmio(rsp_mmio_wr_req, csr_addr_dsm_base, 9'd0, 64'h0004_2a00);
        repeat (2)
        begin
            idle_cycles(1);
            fiu_c1_alm_full <= 1'b1;
        end
        idle_cycles(1);
        afu_c1_tx <= random_write();
        wait_for_writes(1, 0, "accelerator ID write");
        idle_cycles(20);
        check_value("accelerator ID write count", 256'(id_writes), 256'(1));
        report_test("accelerator ID write", errors_before);

        if (!timed_out)
        begin
            errors_before = error_count;
            mmio_before   = mmio_writes;
            for (int i = 0; i < 200; i++)
            begin
                drive_random_cycle(1'b0);
                if (i == 10)
                    fiu_c0_rx <= mmio_request(rsp_mmio_rd_req, csr_addr_dsm_base, 9'h012, '0);
            end
            wait_for_writes(1, mmio_before + 1, "DSM base read response");
            check_value("DSM base read line", 256'(last_mmio_line),
                256'({63'b0, 1'b1, 32'b0, exp_base}));
            report_test("random traffic and back-pressure", errors_before);
        end

        if (!timed_out)
        begin
            errors_before = error_count;
            mmio_before   = mmio_writes;
            scratch       = {$urandom, $urandom};
            send_mmio(rsp_mmio_wr_req, csr_addr_scratch, 9'd0, scratch);
            send_mmio(rsp_mmio_rd_req, csr_addr_scratch, 9'h1a5, '0);
            wait_for_writes(1, mmio_before + 1, "scratch read response");
            check_value("scratch read line", 256'(last_mmio_line), 256'({63'b0, 1'b1, scratch}));
            // An unmapped address reads as zero
            send_mmio(rsp_mmio_rd_req, 16'h0200, 9'h077, '0);
            wait_for_writes(1, mmio_before + 2, "unknown address read response");
            check_value("unknown address read line", 256'(last_mmio_line),
                256'({63'b0, 1'b1, 64'b0}));
            report_test("MMIO read mapped to DSM line 1", errors_before);
        end

        if (!timed_out)
        begin
            errors_before = error_count;
            repeat (60) drive_random_cycle(1'b1);
            idle_cycles(2);
            report_test("write response filtering", errors_before);
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
        if ((error_count == 0) && !timed_out)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
